// File: squeeze_cfg.svh
////////////////////
// Sizes and widths of the squeeze convolution engine
// Include wherever a size or width is needed
////////////////////
`ifndef SQUEEZE_CFG_SVH
`define SQUEEZE_CFG_SVH

// Kernel and channel geometry
`define SQ_CHIN    4
`define SQ_KDIM    3
`define SQ_TAPS    (`SQ_KDIM * `SQ_KDIM * `SQ_CHIN)
`define SQ_CHOUT   4

// Output map, 4x4 windows per run
`define SQ_WINDOWS 16

// Datapath widths
`define SQ_PIX_W   16
`define SQ_ACC_W   40
`define SQ_FRAC    14

// Tap index width, enough for SQ_TAPS
`define SQ_TAP_W   $clog2(`SQ_TAPS)

`endif

// File: squeeze_pkg.sv
////////////////////
// Shared types and coefficient formulas of the squeeze engine
// Imported by the RTL and by the testbench reference model
////////////////////
`include "squeeze_cfg.svh"

package squeeze_pkg;

	// Control of one tap, sequencer to datapath
	typedef struct packed {
		logic                 valid;
		logic                 first;
		logic                 last;
		logic [`SQ_TAP_W-1:0] addr;
	} tap_ctl_t;

	// One requantized value per output channel
	typedef logic [`SQ_CHOUT-1:0][`SQ_PIX_W-1:0] ofm_vec_t;

	// Weights of all channels for one tap
	typedef logic signed [`SQ_CHOUT-1:0][`SQ_PIX_W-1:0] weight_vec_t;

	// Bias per channel, in accumulator units
	typedef logic signed [`SQ_CHOUT-1:0][`SQ_ACC_W-1:0] bias_vec_t;

	// Sequencer states
	typedef enum logic {
		RUN,
		DONE
	} seq_state_e;

	// Weight of channel c at tap t, range +-30 * 512
	function automatic logic signed [`SQ_PIX_W-1:0] coef_weight(input int c, input int t);
		int v;
		v = (((7 * t + 13 * c) % 61) - 30) * 512;
		return `SQ_PIX_W'(v);
	endfunction

	// Bias of channel c, scaled by 2^14
	function automatic logic signed [`SQ_ACC_W-1:0] coef_bias(input int c);
		logic signed [`SQ_ACC_W-1:0] b;
		b = (3 * c - 5) * (1 << `SQ_FRAC);
		return b;
	endfunction

endpackage

// File: coef_rom.sv
////////////////////
// Weight ROM with registered read, plus constant bias table
// Address is the tap index from the sequencer
////////////////////
`timescale 1ns/1ps
`include "squeeze_cfg.svh"

module coef_rom
	import squeeze_pkg::*;
(
	input  logic                 clk,
	input  logic [`SQ_TAP_W-1:0] addr,
	output weight_vec_t          weights,
	output bias_vec_t            bias
);

	////////////////////
	// Weight memory
	////////////////////

	// One weight vector per tap
	weight_vec_t rom_mem [`SQ_TAPS];

	// Constant contents, folded at elaboration
	always_comb begin
		for (int t = 0; t < `SQ_TAPS; t++) begin
			for (int c = 0; c < `SQ_CHOUT; c++) begin
				rom_mem[t][c] = coef_weight(c, t);
			end
		end
	end

	// Registered read
	// one cycle after addr, lines up with the aligned pixel
	always_ff @(posedge clk) begin
		weights <= rom_mem[addr];
	end

	////////////////////
	// Bias table
	////////////////////

	// Combinational, constant per channel
	always_comb begin
		for (int c = 0; c < `SQ_CHOUT; c++) begin
			bias[c] = coef_bias(c);
		end
	end

endmodule

// File: channel_mac.sv
////////////////////
// Signed multiply-accumulate lane, one per output channel
// Loads on the first tap of a window, adds on the rest
////////////////////
`timescale 1ns/1ps
`include "squeeze_cfg.svh"

module channel_mac (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        valid,
	input  logic                        first,
	input  logic signed [`SQ_PIX_W-1:0] pix,
	input  logic signed [`SQ_PIX_W-1:0] ker,
	output logic signed [`SQ_ACC_W-1:0] acc
);

	// Full precision product
	logic signed [2*`SQ_PIX_W-1:0] prod;

	// Product sign extended to accumulator width
	logic signed [`SQ_ACC_W-1:0]   prod_ext;

	assign prod     = pix * ker;
	assign prod_ext = `SQ_ACC_W'(prod);

	// Accumulator
	// first tap restarts the sum, no separate clear cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (valid) begin
			if (first) begin
				acc <= prod_ext;
			end else begin
				acc <= acc + prod_ext;
			end
		end
		// Paused, hold
	end

endmodule

// File: tap_sequencer.sv
////////////////////
// Tap and window counters of the squeeze engine
// Drives tap control to the ROM and datapath, flags done
////////////////////
`timescale 1ns/1ps
`include "squeeze_cfg.svh"

module tap_sequencer
	import squeeze_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     en,
	output tap_ctl_t tap,
	output logic     done
);

	localparam int TAP_W = `SQ_TAP_W;
	localparam int WIN_W = $clog2(`SQ_WINDOWS);

	// Tap within window, window within run
	logic [TAP_W-1:0] tap_cnt;
	logic [WIN_W-1:0] win_cnt;
	seq_state_e       state;

	// Pixel taken this cycle
	logic consume;

	// Boundary flags
	logic tap_last;
	logic win_last;

	////////////////////
	// Tap control
	////////////////////

	assign consume  = en && (state == RUN);
	assign tap_last = (tap_cnt == TAP_W'(`SQ_TAPS - 1));
	assign win_last = (win_cnt == WIN_W'(`SQ_WINDOWS - 1));

	// Valid only on consumed cycles
	assign tap.valid = consume;
	assign tap.first = (tap_cnt == '0);
	assign tap.last  = tap_last;
	assign tap.addr  = tap_cnt;

	assign done = (state == DONE);

	////////////////////
	// Counters and state
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_cnt <= '0;
			win_cnt <= '0;
			state   <= RUN;
		end else if (consume) begin
			if (tap_last) begin
				tap_cnt <= '0;
				// Window boundary
				if (win_last) begin
					win_cnt <= '0;
					state   <= DONE;
				end else begin
					win_cnt <= win_cnt + 1'b1;
				end
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
		// en low or DONE, counters hold
	end

	////////////////////
	// Checks
	////////////////////

	// DONE is sticky and never lets a tap through
	assert property (@(posedge clk) disable iff (!rst)
		state == DONE |=> state == DONE && !tap.valid);

	// Tap count wraps before SQ_TAPS
	assert property (@(posedge clk) disable iff (!rst)
		tap_cnt < `SQ_TAPS);

endmodule

// File: squeeze_conv.sv
////////////////////
// Convolution datapath, pixel alignment, MAC array and output stage
// Bias, ReLU and saturating requantization per channel
////////////////////
`timescale 1ns/1ps
`include "squeeze_cfg.svh"

module squeeze_conv
	import squeeze_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  tap_ctl_t             tap,
	input  logic [`SQ_PIX_W-1:0] ifm,
	input  weight_vec_t          weights,
	input  bias_vec_t            bias,
	output ofm_vec_t             ofm,
	output logic                 sample
);

	// Requantized values at or above this clip to max
	localparam logic signed [`SQ_ACC_W:0] SAT_LIM = 1 <<< (`SQ_FRAC + `SQ_PIX_W - 1);

	// Alignment stage
	logic signed [`SQ_PIX_W-1:0] pix_q;
	tap_ctl_t                    tap_q;

	// Last flag lined up with accumulators
	logic last_d;

	// Per channel accumulators and biased sums
	logic signed [`SQ_ACC_W-1:0] acc [`SQ_CHOUT];
	logic signed [`SQ_ACC_W:0]   sum [`SQ_CHOUT];

	// ReLU, clip, drop fraction
	function automatic logic [`SQ_PIX_W-1:0] requant(input logic signed [`SQ_ACC_W:0] s);
		if (s < 0) begin
			return '0;
		end else if (s >= SAT_LIM) begin
			return {1'b0, {(`SQ_PIX_W-1){1'b1}}};
		end
		return {1'b0, s[`SQ_FRAC +: `SQ_PIX_W-1]};
	endfunction

	////////////////////
	// Pixel alignment
	////////////////////

	// Pixel payload, meets ROM output one cycle later
	always_ff @(posedge clk) begin
		pix_q <= $signed(ifm);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_q  <= '0;
			last_d <= 1'b0;
		end else begin
			tap_q  <= tap;
			last_d <= tap_q.valid && tap_q.last;
		end
	end

	////////////////////
	// MAC array
	////////////////////

	for (genvar c = 0; c < `SQ_CHOUT; c++) begin : g_lane
		channel_mac u_mac (
			.clk   (clk),
			.rst   (rst),
			.valid (tap_q.valid),
			.first (tap_q.first),
			.pix   (pix_q),
			.ker   ($signed(weights[c])),
			.acc   (acc[c])
		);

		// Bias add, one extra bit of headroom
		assign sum[c] = $signed({acc[c][`SQ_ACC_W-1], acc[c]})
			+ $signed({bias[c][`SQ_ACC_W-1], bias[c]});
	end

	////////////////////
	// Output stage
	////////////////////

	// Held between samples
	always_ff @(posedge clk) begin
		if (last_d) begin
			for (int c = 0; c < `SQ_CHOUT; c++) begin
				ofm[c] <= requant(sum[c]);
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sample <= 1'b0;
		end else begin
			sample <= last_d;
		end
	end

	// A window takes SQ_TAPS cycles, strobes never touch
	assert property (@(posedge clk) disable iff (!rst) sample |=> !sample);

endmodule

// File: squeeze_top.sv
////////////////////
// Top of the squeeze convolution engine
// Pixel stream in under en, one ofm vector per window out
////////////////////
`timescale 1ns/1ps
`include "squeeze_cfg.svh"

module squeeze_top
	import squeeze_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 en,
	input  logic [`SQ_PIX_W-1:0] ifm,
	output ofm_vec_t             ofm,
	output logic                 sample,
	output logic                 done
);

	// Tap control and coefficients
	tap_ctl_t    tap;
	weight_vec_t weights;
	bias_vec_t   bias;

	tap_sequencer u_seq (
		.clk  (clk),
		.rst  (rst),
		.en   (en),
		.tap  (tap),
		.done (done)
	);

	coef_rom u_rom (
		.clk     (clk),
		.addr    (tap.addr),
		.weights (weights),
		.bias    (bias)
	);

	squeeze_conv u_conv (
		.clk     (clk),
		.rst     (rst),
		.tap     (tap),
		.ifm     (ifm),
		.weights (weights),
		.bias    (bias),
		.ofm     (ofm),
		.sample  (sample)
	);

endmodule

// File: tb_squeeze_top.sv
////////////////////
// Self-checking testbench of the squeeze convolution engine
// Streams LCG pixels under en, checks every ofm vector and strobe timing
////////////////////
`timescale 1ns/1ps
`include "squeeze_cfg.svh"

module tb_squeeze_top
	import squeeze_pkg::*;
();

	localparam int          TAPS     = `SQ_TAPS;
	localparam int          TOTAL    = `SQ_WINDOWS * `SQ_TAPS;
	localparam int          EN_LEN   = 2 * TOTAL;
	localparam int          RST_CYC  = 4;
	localparam int          IDLE     = 20;
	// Mid-run reset lands one pixel into window 3
	localparam int          CUT      = 3 * `SQ_TAPS + 1;
	localparam logic [31:0] LCG_SEED = 32'he0cf;

	// Clip cases forced into the table
	localparam int               SAT_WIN = 5;
	localparam int               SAT_CH  = 3;
	localparam int               NEG_WIN = 9;
	localparam int               NEG_CH  = 0;
	localparam logic [`SQ_PIX_W-1:0] PIX_MAX = 16'h1fff;
	localparam logic [`SQ_PIX_W-1:0] PIX_MIN = 16'he000;

	logic                 clk;
	logic                 rst;
	logic                 en;
	logic [`SQ_PIX_W-1:0] ifm;
	ofm_vec_t             ofm;
	logic                 sample;
	logic                 done;

	// Stimulus and expected tables
	logic [`SQ_PIX_W-1:0] pix_tab [TOTAL];
	logic                 en_pat  [EN_LEN];
	ofm_vec_t             exp_tab [`SQ_WINDOWS];

	// Monitor bookkeeping
	int neg_cnt   = 0;
	int consumed  = 0;
	int exp_idx   = 0;
	int wd_limit  = 0;
	int due [$];

	squeeze_top uut (
		.clk    (clk),
		.rst    (rst),
		.en     (en),
		.ifm    (ifm),
		.ofm    (ofm),
		.sample (sample),
		.done   (done)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	////////////////////
	// Stimulus and reference model
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic void fill_tables();
		logic [31:0] s;
		s = LCG_SEED;
		// Pixels within +-2^13
		for (int i = 0; i < TOTAL; i++) begin
			s = lcg_next(s);
			pix_tab[i] = {{2{s[29]}}, s[29:16]};
		end
		// Roughly three quarters of cycles enabled
		for (int k = 0; k < EN_LEN; k++) begin
			s = lcg_next(s);
			en_pat[k] = (s[31:30] != 2'b00);
		end
		// Every product positive on the saturating channel
		for (int t = 0; t < TAPS; t++) begin
			pix_tab[SAT_WIN * TAPS + t] = (coef_weight(SAT_CH, t) < 0) ? PIX_MIN : PIX_MAX;
		end
		// Every product negative here
		for (int t = 0; t < TAPS; t++) begin
			pix_tab[NEG_WIN * TAPS + t] = (coef_weight(NEG_CH, t) < 0) ? PIX_MAX : PIX_MIN;
		end
	endfunction

	// ReLU, clip at 2^29, drop 14 fraction bits
	function automatic logic [`SQ_PIX_W-1:0] ref_requant(input longint s);
		if (s < 0) begin
			return '0;
		end
		if (s >= (longint'(1) << (`SQ_FRAC + `SQ_PIX_W - 1))) begin
			return 16'h7fff;
		end
		return `SQ_PIX_W'(s >> `SQ_FRAC);
	endfunction

	function automatic void build_expected();
		longint acc;
		longint wgt;
		longint px;
		longint b;
		for (int w = 0; w < `SQ_WINDOWS; w++) begin
			for (int c = 0; c < `SQ_CHOUT; c++) begin
				acc = 0;
				for (int t = 0; t < TAPS; t++) begin
					wgt = coef_weight(c, t);
					px  = $signed(pix_tab[w * TAPS + t]);
					acc = acc + px * wgt;
				end
				b = coef_bias(c);
				exp_tab[w][c] = ref_requant(acc + b);
			end
		end
	endfunction

	// Paused cycles needed by the random en pattern
	function automatic int count_gaps();
		int ones;
		int gaps;
		int k;
		ones = 0;
		gaps = 0;
		k    = 0;
		while (ones < TOTAL) begin
			if (en_pat[k % EN_LEN]) begin
				ones++;
			end else begin
				gaps++;
			end
			k++;
		end
		return gaps;
	endfunction

	////////////////////
	// Drivers
	////////////////////

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b0;
		en  <= 1'b0;
		repeat (RST_CYC) @(posedge clk);
		rst <= 1'b1;
	endtask

	// Paused cycles carry junk on ifm
	task automatic drive_stream(input bit use_gaps, input int n_pix);
		int  idx;
		int  k;
		logic e;
		idx = 0;
		k   = 0;
		while (idx < n_pix) begin
			e = use_gaps ? en_pat[k % EN_LEN] : 1'b1;
			@(posedge clk);
			en  <= e;
			ifm <= e ? pix_tab[idx] : ~pix_tab[idx];
			if (e) begin
				idx++;
			end
			k++;
		end
	endtask

	// en stays high past done
	task automatic idle_high(input int n);
		repeat (n) begin
			@(posedge clk);
			en  <= 1'b1;
			ifm <= 16'h5a5a;
		end
	endtask

	task automatic check_run_end();
		@(posedge clk);
		assert (exp_idx == `SQ_WINDOWS) else
			report_failure($sformatf("Run ended at %0t with %0d sample pulses instead of %0d",
				$time, exp_idx, `SQ_WINDOWS));
		assert (done) else report_failure("done is low after the last window");
	endtask

	////////////////////
	// Monitor
	////////////////////

	always @(negedge clk) begin
		neg_cnt++;
		if (!rst) begin
			assert (!sample && !done) else
				report_failure($sformatf("sample or done high during reset at %0t", $time));
			consumed = 0;
			exp_idx  = 0;
			due.delete();
		end else begin
			// done only once every pixel is in
			assert (done == (consumed == TOTAL)) else
				report_failure($sformatf("done is %0b at %0t after %0d pixels",
					done, $time, consumed));
			if (sample) begin
				assert (due.size() > 0 && due[0] == neg_cnt) else
					report_failure($sformatf("Unexpected sample pulse at %0t", $time));
				void'(due.pop_front());
				assert (exp_idx < `SQ_WINDOWS) else
					report_failure("More sample pulses than windows");
				for (int c = 0; c < `SQ_CHOUT; c++) begin
					assert (ofm[c] == exp_tab[exp_idx][c]) else
						report_failure($sformatf(
							"Mismatch at %0t: ofm[%0d] window %0d expected %0d got %0d",
							$time, c, exp_idx, exp_tab[exp_idx][c], ofm[c]));
				end
				exp_idx++;
			end else begin
				assert (due.size() == 0 || due[0] != neg_cnt) else
					report_failure($sformatf("Missing sample pulse at %0t", $time));
			end
			// Next edge takes a pixel, strobe three edges on from the last tap
			if (en && !done) begin
				if (consumed % TAPS == TAPS - 1) begin
					due.push_back(neg_cnt + 3);
				end
				consumed++;
			end
		end
	end

	// Watchdog
	initial begin
		wait (wd_limit > 0);
		repeat (wd_limit) @(posedge clk);
		report_failure($sformatf("Watchdog expired after %0d cycles, stream never finished",
			wd_limit));
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst = 1'b0;
		en  = 1'b0;
		ifm = '0;
		fill_tables();
		build_expected();
		assert (exp_tab[SAT_WIN][SAT_CH] == 16'h7fff) else
			report_failure("Saturating window does not reach the clip limit");
		assert (exp_tab[NEG_WIN][NEG_CH] == 16'h0000) else
			report_failure("Negative window does not clip to zero");
		wd_limit = 2 * (3 * TOTAL + CUT + count_gaps() + 3 * (RST_CYC + IDLE) + 20);
		repeat (RST_CYC) @(posedge clk);
		rst <= 1'b1;

		// Continuous stream, then en held past done
		drive_stream(1'b0, TOTAL);
		idle_high(IDLE);
		check_run_end();

		// Same pixels with random pauses
		apply_reset();
		drive_stream(1'b1, TOTAL);
		idle_high(IDLE);
		check_run_end();

		// Reset with a strobe in flight, then a full restart
		apply_reset();
		drive_stream(1'b0, CUT);
		apply_reset();
		drive_stream(1'b0, TOTAL);
		idle_high(IDLE);
		check_run_end();

		$display("all tests passed");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
squeeze_pkg.sv
coef_rom.sv
channel_mac.sv
tap_sequencer.sv
squeeze_conv.sv
squeeze_top.sv
tb_squeeze_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the squeeze engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
	--top-module tb_squeeze_top \
	-f all.f

status=0
./obj_dir/Vtb_squeeze_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL (exit status $status)"
	exit 1
fi
